// File: src/rv_pkg.sv
package rv_pkg;

    // Datapath and instruction widths
    typedef logic [63:0] word_t;      // Data word or byte address
    typedef logic [31:0] inst_t;      // One instruction word
    typedef logic [4:0]  reg_idx_t;   // Register number x0..x31
    typedef logic [6:0]  imem_addr_t; // Instruction word index

    // Load sequence through the I/O bus
    typedef enum logic [1:0] {
        load_idle,    // No load in flight
        load_wait,    // Read strobe out, I/O block registering data
        load_capture  // Read data valid, written into x5
    } load_step_e;

    // Instruction memory size in words
    localparam int imem_depth = 128;

    // Program layout
    localparam word_t reset_pc = 64'h0000_0000_0000_0080; // Main program, word 32
    localparam word_t isr_pc   = 64'h0000_0000_0000_0000; // Handler in words 0..31

    // I/O map
    localparam word_t key_base = 64'h0000_0000_0000_2000; // Key input register
    localparam word_t art_base = 64'h0000_0000_0000_3000; // Art output register

    // Encodings
    localparam logic [6:0] opcode_lui = 7'b0110111;
    localparam inst_t inst_mret  = 32'h0000_0000;   // All zero word
    localparam inst_t inst_load  = 32'hFFFF_FFFF;   // Load key into x5
    localparam inst_t inst_store = 32'hFFFF_FF7F;   // rd = 30, store x5 to art

    // Value of ir after reset, decodes as a no-op
    localparam inst_t ir_reset_value = 32'h0000_0001;

    // External interrupt vector number
    localparam logic [3:0] irq_vec_ext = 4'd1;

endpackage

// File: src/inst_mem.sv
module inst_mem (
    input  logic               clk,
    input  logic               we,           // Loader write strobe
    input  rv_pkg::imem_addr_t waddr,        // Loader word index
    input  rv_pkg::inst_t      wdata,
    input  rv_pkg::word_t      pc,           // Byte address from the core
    output rv_pkg::inst_t      instruction
);
    import rv_pkg::*;

    inst_t      mem [imem_depth];  // Program storage
    imem_addr_t raddr;

    // Word index from the byte address
    assign raddr = pc[8:2];

    // Loader writes at the clock edge
    always_ff @(posedge clk) begin
        if (we) mem[waddr] <= wdata;
    end

    // Fetch is combinational, ir registers it in the core
    assign instruction = mem[raddr];

endmodule

// File: src/irq_ctrl.sv
module irq_ctrl (
    input  logic       clk,
    input  logic       reset,
    input  logic       irq_button,        // Asynchronous push button
    input  logic       interrupt_ack,     // Core took the request
    output logic [3:0] interrupt_vector
);
    import rv_pkg::*;

    logic sync_q1;     // First synchronizer stage
    logic sync_q2;     // Second stage, safe to use
    logic button_q;    // Previous synchronized level
    logic button_rise;
    logic request;     // Held until acknowledged

    assign button_rise = sync_q2 && !button_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            sync_q1  <= 1'b0;
            sync_q2  <= 1'b0;
            button_q <= 1'b0;
            request  <= 1'b0;
        end else begin
            sync_q1  <= irq_button;
            sync_q2  <= sync_q1;
            button_q <= sync_q2;
            // A fresh edge beats a same cycle ack
            if (button_rise)        request <= 1'b1;
            else if (interrupt_ack) request <= 1'b0;
        end
    end

    // Vector only shown while a request is held
    assign interrupt_vector = request ? irq_vec_ext : 4'd0;

endmodule

// File: src/mmio_io.sv
module mmio_io (
    input  logic          clk,
    input  logic          reset,
    input  rv_pkg::word_t bus_address,
    input  rv_pkg::word_t bus_write_data,
    input  logic          bus_write_enable,
    input  logic          bus_read_enable,
    output rv_pkg::word_t bus_read_data,   // One cycle after the read strobe
    input  logic [15:0]   key_in,          // Switches from outside
    output rv_pkg::word_t art_data,
    output logic          art_valid        // Pulse after each art write
);
    import rv_pkg::*;

    logic  key_sel;    // Address hits the key register
    logic  art_sel;    // Address hits the art register
    logic  key_read;
    logic  art_write;
    word_t key_reg;    // Sampled key input

    // Full address compare, no aliasing
    assign key_sel = (bus_address == key_base);
    assign art_sel = (bus_address == art_base);

    assign key_read  = bus_read_enable && key_sel;
    assign art_write = bus_write_enable && art_sel;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            key_reg       <= '0;
            bus_read_data <= '0;
            art_valid     <= 1'b0;
        end else begin
            key_reg <= {48'b0, key_in};   // Resampled every cycle
            // Unmapped or idle reads return 0
            bus_read_data <= key_read ? key_reg : '0;
            art_valid     <= art_write;   // High in the cycle after the write
        end
    end

    // Art value held until the next write
    always_ff @(posedge clk) begin
        if (art_write) art_data <= bus_write_data;
    end

endmodule

// File: src/rv_core.sv
module rv_core (
    input  logic          clk,
    input  logic          reset,
    input  rv_pkg::inst_t instruction,       // Word at pc from instruction memory
    output rv_pkg::word_t pc,
    output logic          heartbeat,
    input  logic [3:0]    interrupt_vector,
    output logic          interrupt_pending,  // High from entry until MRET
    output logic          interrupt_ack,      // One cycle pulse on entry
    output rv_pkg::word_t bus_address,
    output rv_pkg::word_t bus_write_data,
    output logic          bus_write_enable,
    output logic          bus_read_enable,
    input  rv_pkg::word_t bus_read_data
);
    import rv_pkg::*;

    inst_t      ir;               // Executing instruction
    word_t      mepc;             // Return address for MRET
    logic       bubble;           // Next ir is stale after a pc jump
    load_step_e load_step;
    word_t      regs [32];        // Register file, x0 never written

    // Decode fields
    reg_idx_t rd;
    word_t    imm_u;

    // Decode flags
    logic is_lui;
    logic is_mret;
    logic is_load;
    logic is_store;

    logic take_irq;    // Interrupt taken this cycle
    logic exec_valid;  // ir is executed this cycle

    // Register file write port
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;

    assign rd    = ir[11:7];
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0}; // U immediate, sign from bit 31

    // Interrupts wait until a load sequence has finished
    assign take_irq   = (interrupt_vector == irq_vec_ext) && !interrupt_pending &&
                        (load_step == load_idle);
    assign exec_valid = !take_irq && !bubble && (load_step == load_idle);

    // Instruction decode, anything unmatched is a no-op
    always_comb begin
        is_lui   = 1'b0;
        is_mret  = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        casez (ir)
            inst_mret:              is_mret  = 1'b1;
            inst_load:              is_load  = 1'b1;
            inst_store:             is_store = 1'b1;
            {25'b?, opcode_lui}:    is_lui   = 1'b1;
            default: ;
        endcase
    end

    // Write source for the register file
    always_comb begin
        rf_we    = 1'b0;
        rf_waddr = rd;
        rf_wdata = imm_u;
        if (load_step == load_capture) begin
            rf_we    = 1'b1;             // Key value lands in x5
            rf_waddr = reg_idx_t'(5);
            rf_wdata = bus_read_data;
        end else if (exec_valid && is_lui && rd != '0) begin
            rf_we = 1'b1;                // LUI, x0 writes dropped
        end
    end

    always_ff @(posedge clk) begin
        if (rf_we) regs[rf_waddr] <= rf_wdata;
    end

    // Fetch register and heartbeat
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir        <= ir_reset_value;
            heartbeat <= 1'b0;
        end else begin
            ir        <= instruction;    // Word fetched at current pc
            heartbeat <= ~heartbeat;
        end
    end

    // Execute, pc update and bus strobes
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc                <= reset_pc;
            mepc              <= reset_pc;
            bubble            <= 1'b0;
            load_step         <= load_idle;
            interrupt_pending <= 1'b0;
            interrupt_ack     <= 1'b0;
            bus_address       <= '0;
            bus_write_data    <= '0;
            bus_write_enable  <= 1'b0;
            bus_read_enable   <= 1'b0;
        end else begin
            pc               <= pc + 64'd4; // Sequential fetch unless overridden
            interrupt_ack    <= 1'b0;
            bus_write_enable <= 1'b0;       // Strobes last one cycle by default
            bus_read_enable  <= 1'b0;

            if (take_irq) begin
                mepc              <= pc;    // Word after the discarded ir
                pc                <= isr_pc;
                bubble            <= 1'b1;  // Drop the word fetched at old pc
                interrupt_pending <= 1'b1;
                interrupt_ack     <= 1'b1;
            end else if (load_step == load_wait) begin
                pc              <= pc;      // Still stalled
                bus_read_enable <= 1'b1;    // Second cycle of read strobe
                load_step       <= load_capture;
            end else if (load_step == load_capture) begin
                load_step <= load_idle;     // x5 written by the regfile port
            end else if (bubble) begin
                bubble <= 1'b0;             // Stale ir skipped
            end else begin
                if (is_mret) begin
                    pc                <= mepc;
                    bubble            <= 1'b1;
                    interrupt_pending <= 1'b0;
                end
                if (is_load) begin
                    bus_address     <= key_base;
                    bus_read_enable <= 1'b1;
                    pc              <= pc;  // Hold so next word is refetched
                    load_step       <= load_wait;
                end
                if (is_store) begin
                    bus_address      <= art_base;
                    bus_write_data   <= regs[5];
                    bus_write_enable <= 1'b1;
                end
            end
        end
    end

endmodule

// File: src/rv_soc.sv
module rv_soc (
    input  logic               clk,
    input  logic               reset,
    // Program loader
    input  logic               imem_we,
    input  rv_pkg::imem_addr_t imem_addr,
    input  rv_pkg::inst_t      imem_data,
    // Board inputs
    input  logic               irq_button,
    input  logic [15:0]        key_in,
    // Board outputs
    output rv_pkg::word_t      art_data,
    output logic               art_valid,
    output logic               heartbeat,
    output logic               interrupt_pending
);
    import rv_pkg::*;

    // Fetch path
    word_t pc;
    inst_t instruction;

    // Interrupt path
    logic [3:0] interrupt_vector;
    logic       interrupt_ack;

    // I/O bus
    word_t bus_address;
    word_t bus_write_data;
    word_t bus_read_data;
    logic  bus_write_enable;
    logic  bus_read_enable;

    rv_core u_core (
        .clk               (clk),
        .reset             (reset),
        .instruction       (instruction),
        .pc                (pc),
        .heartbeat         (heartbeat),
        .interrupt_vector  (interrupt_vector),
        .interrupt_pending (interrupt_pending),
        .interrupt_ack     (interrupt_ack),
        .bus_address       (bus_address),
        .bus_write_data    (bus_write_data),
        .bus_write_enable  (bus_write_enable),
        .bus_read_enable   (bus_read_enable),
        .bus_read_data     (bus_read_data)
    );

    inst_mem u_imem (
        .clk         (clk),
        .we          (imem_we),
        .waddr       (imem_addr),
        .wdata       (imem_data),
        .pc          (pc),
        .instruction (instruction)
    );

    irq_ctrl u_irq (
        .clk              (clk),
        .reset            (reset),
        .irq_button       (irq_button),
        .interrupt_ack    (interrupt_ack),
        .interrupt_vector (interrupt_vector)
    );

    mmio_io u_io (
        .clk              (clk),
        .reset            (reset),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .key_in           (key_in),
        .art_data         (art_data),
        .art_valid        (art_valid)
    );

endmodule

// File: test/rv_soc_chk.sv
module rv_soc_chk (
    input logic clk,
    input logic reset,
    input logic art_valid,
    input logic heartbeat,
    input logic interrupt_pending,
    input logic interrupt_ack,
    input logic bus_write_enable,
    input logic bus_read_enable
);
    timeunit 1ns;
    timeprecision 1ps;

    // Art pulse lasts one cycle
    a_art_single: assert property (@(posedge clk) disable iff (!reset)
        art_valid |=> !art_valid)
        else $error("art_valid high for two cycles in a row");

    // Bus carries one transfer at a time
    a_bus_excl: assert property (@(posedge clk) disable iff (!reset)
        !(bus_write_enable && bus_read_enable))
        else $error("bus read and write strobes high together");

    // Handler still running in the cycle after the entry pulse
    a_ack_pending: assert property (@(posedge clk) disable iff (!reset)
        interrupt_ack |=> interrupt_pending)
        else $error("interrupt_pending low right after interrupt_ack");

    a_heartbeat: assert property (@(posedge clk) disable iff (!reset)
        1'b1 |=> (heartbeat != $past(heartbeat)))  // Flips on every edge
        else $error("heartbeat did not toggle");

endmodule

bind rv_soc rv_soc_chk u_chk (
    .clk               (clk),
    .reset             (reset),
    .art_valid         (art_valid),
    .heartbeat         (heartbeat),
    .interrupt_pending (interrupt_pending),
    .interrupt_ack     (interrupt_ack),
    .bus_write_enable  (bus_write_enable),
    .bus_read_enable   (bus_read_enable)
);

// File: test/rv_soc_tb.sv
module rv_soc_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_pkg::*;

    localparam int num_tests     = 5;
    localparam int timeout_limit = num_tests * 400; // Worst case per test

    // Special encodings of this core
    localparam inst_t load_word  = 32'hFFFF_FFFF;
    localparam inst_t store_word = 32'hFFFF_FF7F; // rd = 30
    localparam inst_t mret_word  = 32'h0000_0000;

    logic        clk;
    logic        reset;
    logic        imem_we;
    imem_addr_t  imem_addr;
    inst_t       imem_data;
    logic        irq_button;
    logic [15:0] key_in;
    word_t       art_data;
    logic        art_valid;
    logic        heartbeat;
    logic        interrupt_pending;

    inst_t       prog [imem_depth]; // Image written by the loader
    word_t       art_q [$];         // Art values since reset release
    logic [31:0] lcg_state;
    int          cycles = 0;
    int          checks;
    int          errors;
    int          test_errors;

    rv_soc uut (
        .clk               (clk),
        .reset             (reset),
        .imem_we           (imem_we),
        .imem_addr         (imem_addr),
        .imem_data         (imem_data),
        .irq_button        (irq_button),
        .key_in            (key_in),
        .art_data          (art_data),
        .art_valid         (art_valid),
        .heartbeat         (heartbeat),
        .interrupt_pending (interrupt_pending)
    );

    always #50 clk = ~clk;

    // Hard stop for a hung run
    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_limit) begin
            $display("Run stopped: no result after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // Outputs settle long before the falling edge
    always @(negedge clk) begin
        if (reset && art_valid) art_q.push_back(art_data);
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // addi x0 with the word index as immediate
    function automatic inst_t nop_at(input int idx);
        imem_addr_t a;
        a = imem_addr_t'(idx);
        return {5'b0, a, 20'h00013};
    endfunction

    function automatic inst_t lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    // Upper 20 bits placed at bit 12, then sign-extended from bit 31
    function automatic word_t lui_value(input logic [19:0] imm);
        logic [31:0] upper;
        upper = {imm, 12'h000};
        return {{32{upper[31]}}, upper};
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic clear_program();
        for (int i = 0; i < imem_depth; i++) prog[i] = nop_at(i);
    endtask

    // Whole image goes in while the core is held in reset
    task automatic load_program();
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < imem_depth; i++) begin
            imem_we   = 1'b1;
            imem_addr = imem_addr_t'(i);
            imem_data = prog[i];
            @(negedge clk);
        end
        imem_we = 1'b0;
        repeat (5) @(negedge clk);
        art_q.delete();
        test_errors = 0;
        reset = 1'b1;
    endtask

    task automatic wait_art(input int count, input int limit);
        int n;
        n = 0;
        while (art_q.size() < count && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (art_q.size() < count) begin
            $display("Error: only %0d of %0d art values arrived", art_q.size(), count);
            test_errors++;
        end
    endtask

    task automatic wait_pending(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (interrupt_pending !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (interrupt_pending !== level) begin
            $display("Error: interrupt_pending stuck at %b while %s", interrupt_pending, what);
            test_errors++;
        end
    endtask

    task automatic press_button();
        irq_button = 1'b1;
        repeat (2) @(negedge clk); // Wide enough for the synchronizer
        irq_button = 1'b0;
    endtask

    task automatic finish_test(input string name);
        errors += test_errors;
        $display("Test %s: %0d errors", name, test_errors);
    endtask

    // Index of the first main value after the first handler value, or -1
    function automatic int find_return(input word_t isr_val, input word_t main_val);
        int first_isr;
        int result;
        first_isr = -1;
        result    = -1;
        foreach (art_q[i]) begin
            if (first_isr < 0 && art_q[i] == isr_val) first_isr = i;
            else if (first_isr >= 0 && result < 0 && art_q[i] == main_val) result = i;
        end
        return result;
    endfunction

    // Handler in words 0..12, main loop of LUI and store from word 32
    task automatic build_irq_program(input logic [19:0] main_imm, input logic [19:0] isr_imm);
        clear_program();
        prog[0]  = lui_word(5'd5, isr_imm);
        prog[1]  = store_word;
        prog[10] = lui_word(5'd5, main_imm); // Main value back in x5 before return
        prog[12] = mret_word;
        for (int w = 32; w < imem_depth; w += 4) begin
            prog[w]     = lui_word(5'd5, main_imm);
            prog[w + 1] = store_word;
        end
    endtask

    task automatic test_idle();
        logic prev_hb;
        clear_program();
        load_program();
        prev_hb = heartbeat;
        repeat (20) begin
            @(negedge clk);
            checks += 3;
            if (art_valid !== 1'b0) begin
                $display("** Error: art_valid = %h, expected 0", art_valid);
                test_errors++;
            end
            if (interrupt_pending !== 1'b0) begin
                $display("** Error: interrupt_pending = %h, expected 0", interrupt_pending);
                test_errors++;
            end
            if (heartbeat !== ~prev_hb) begin
                $display("** Error: heartbeat = %h, expected %h", heartbeat, ~prev_hb);
                test_errors++;
            end
            prev_hb = heartbeat;
        end
        finish_test("idle");
    endtask

    task automatic test_lui_store();
        logic [19:0] imm [5];
        logic [31:0] r;
        clear_program();
        for (int i = 0; i < 5; i++) begin
            r = next_random();
            imm[i] = r[31:12];
        end
        if (imm[3] == imm[2]) imm[3] = ~imm[2]; // Keep a stray x0 write visible
        for (int k = 0; k < 3; k++) begin
            prog[32 + 3 * k] = lui_word(5'd5, imm[k]);
            prog[33 + 3 * k] = store_word;
        end
        prog[41] = lui_word(5'd0, imm[3]); // Dropped, x0 stays zero
        prog[42] = store_word;             // x5 still holds the third value
        prog[44] = lui_word(5'd5, imm[4]);
        prog[45] = store_word;
        load_program();
        wait_art(5, 100);
        if (art_q.size() >= 5) begin
            for (int k = 0; k < 3; k++) check_value("art_data", art_q[k], lui_value(imm[k]));
            check_value("art_data", art_q[3], lui_value(imm[2]));
            check_value("art_data", art_q[4], lui_value(imm[4]));
        end
        finish_test("lui_store");
    endtask

    task automatic test_load_store();
        logic [15:0] key [3];
        logic [31:0] r;
        clear_program();
        for (int k = 0; k < 3; k++) begin
            r = next_random();
            key[k] = r[23:8];
            prog[32 + 22 * k] = load_word;  // Loads spaced so key_in can change
            prog[33 + 22 * k] = store_word;
        end
        key_in = key[0];
        load_program();
        for (int k = 0; k < 3; k++) begin
            wait_art(k + 1, 60);
            if (art_q.size() >= k + 1) check_value("art_data", art_q[k], {48'h0, key[k]});
            if (k < 2) key_in = key[k + 1]; // Next load is many cycles away
        end
        finish_test("load_store");
    endtask

    task automatic test_interrupt();
        logic [31:0] r;
        logic [19:0] main_imm;
        logic [19:0] isr_imm;
        int          hits;
        int          n_before;
        r = next_random();
        main_imm = r[31:12];
        r = next_random();
        isr_imm = r[31:12];
        if (isr_imm == main_imm) isr_imm = ~main_imm;
        build_irq_program(main_imm, isr_imm);
        load_program();
        repeat (10) @(negedge clk);
        press_button();
        wait_pending(1'b1, 20, "waiting for interrupt entry");
        wait_pending(1'b0, 60, "waiting for MRET");
        n_before = art_q.size();
        wait_art(n_before + 1, 20);
        hits = 0;
        foreach (art_q[i]) if (art_q[i] == lui_value(isr_imm)) hits++;
        check_value("handler art count", word_t'(hits), word_t'(1));
        if (art_q.size() > n_before)
            check_value("art_data", art_q[art_q.size() - 1], lui_value(main_imm));
        checks++;
        if (interrupt_pending !== 1'b0) begin
            $display("** Error: interrupt_pending = %h, expected 0", interrupt_pending);
            test_errors++;
        end
        finish_test("interrupt");
    endtask

    task automatic test_nested_press();
        logic [31:0] r;
        logic [19:0] main_imm;
        logic [19:0] isr_imm;
        int          idx;
        int          hits;
        int          n;
        r = next_random();
        main_imm = r[31:12];
        r = next_random();
        isr_imm = r[31:12];
        if (isr_imm == main_imm) isr_imm = ~main_imm;
        build_irq_program(main_imm, isr_imm);
        load_program();
        repeat (10) @(negedge clk);
        press_button();
        wait_pending(1'b1, 20, "waiting for interrupt entry");
        press_button();                       // Lands while the handler runs
        n = 0;
        while (find_return(lui_value(isr_imm), lui_value(main_imm)) < 0 && n < 150) begin
            @(negedge clk);
            n++;
        end
        idx = find_return(lui_value(isr_imm), lui_value(main_imm));
        if (idx < 0) begin
            $display("Error: main program did not resume after the handler");
            test_errors++;
        end else begin
            hits = 0;
            for (int i = 0; i < idx; i++) if (art_q[i] == lui_value(isr_imm)) hits++;
            check_value("handler art count", word_t'(hits), word_t'(2));
            checks++;
            if (interrupt_pending !== 1'b0) begin
                $display("** Error: interrupt_pending = %h, expected 0", interrupt_pending);
                test_errors++;
            end
        end
        finish_test("nested_press");
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b0;
        imem_we     = 1'b0;
        imem_addr   = '0;
        imem_data   = '0;
        irq_button  = 1'b0;
        key_in      = '0;
        lcg_state   = 32'h3dec;
        checks      = 0;
        errors      = 0;
        test_errors = 0;

        test_idle();
        test_lui_store();
        test_load_store();
        test_interrupt();
        test_nested_press();

        $display("Tests: %0d, checks: %0d, errors: %0d", num_tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: compile.f
src/rv_pkg.sv
src/inst_mem.sv
src/irq_ctrl.sv
src/mmio_io.sv
src/rv_core.sv
src/rv_soc.sv
test/rv_soc_chk.sv
test/rv_soc_tb.sv

// File: Makefile
TOP := rv_soc_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f compile.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
